/* tb/cpu_testdata.txt */
# M <addr> <word> : preload a memory word, hex
# E <name> <addr> <word> : expected memory word after HLT, hex
# Program: immediates and R-type ALU results
M 00 6112
M 01 5534
M 02 4385
M 03 8140
M 04 8341
M 05 F780
M 06 8242
M 07 F781
M 08 8243
M 09 F782
M 0A 8244
M 0B F783
M 0C 8245
M 0D F784
M 0E 8246
M 0F F785
M 10 8247
M 11 F786
M 12 8248
M 13 FF87
M 14 8249
# Program: load and store copy
M 15 4150
M 16 7710
M 17 870A
M 18 87FE
# Program: branches, each followed by a marker store
M 19 1001
M 1A 8350
M 1B 1101
M 1C 8351
M 1D 0101
M 1E 8352
M 1F 0001
M 20 8353
M 21 2401
M 22 8354
M 23 2001
M 24 8355
M 25 3C01
M 26 8356
M 27 3401
M 28 8357
# Program: jumps with poison stores, then HLT
M 29 902B
M 2A 8358
M 2B A02D
M 2C 8359
M 2D 824A
M 2E 4131
M 2F F419
M 30 835B
M 31 4134
M 32 F41A
M 33 835C
M 34 824B
M 35 F01D
M 36 835D
# Data words
M 60 BEEF
M 50 0000
M 51 0000
M 52 0000
M 53 0000
M 54 0000
M 55 0000
M 56 0000
M 57 0000
M 58 0000
M 59 0000
M 5B 0000
M 5C 0000
M 5D 0000
# Expected results
E lhi_ori 40 1234
E adi_neg 41 FF85
E add 42 11B9
E sub 43 12AF
E and 44 1204
E orr 45 FFB5
E not 46 EDCB
E tcp 47 EDCC
E shl 48 2468
E shr_arith 49 FFC2
E lwd_swd_copy 5A BEEF
E swd_neg_offset 4E BEEF
E beq_taken 50 0000
E beq_not_taken 51 BEEF
E bne_taken 52 0000
E bne_not_taken 53 BEEF
E bgz_taken 54 0000
E bgz_not_taken 55 BEEF
E blz_taken 56 0000
E blz_not_taken 57 BEEF
E jmp_skip 58 0000
E jal_skip 59 0000
E jal_link 4A 002C
E jpr_skip 5B 0000
E jrl_skip 5C 0000
E jrl_link 4B 0033
E after_hlt 5D 0000

/* list.f */
+incdir+src
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/pc_counter.sv
src/cpu_fsm.sv
src/cpu_core.sv
tb/cpu_asserts.sv
tb/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu
BUILD_DIR ?= obj_dir
FILELIST ?= list.f
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= Test completed successfully

SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_cpu.sv */
`include "cpu_macros.svh"

module tb_cpu;

	localparam int MEM_WORDS = 256;
	localparam int MAX_CYCLES = 5000;
	localparam int SEED = 62587;

	typedef struct packed {
		logic [127:0] name;
		logic [7:0] addr;
		logic [`WORD_SIZE-1:0] value;
	} expect_t;

	logic ackOutput;
	logic reset_n = 1'b0;
	logic [`WORD_SIZE-1:0] data_in = '0;
	logic inputReady = 1'b0;
	logic write_ack = 1'b0;
	logic [`WORD_SIZE-1:0] address;
	logic [`WORD_SIZE-1:0] data_out;
	logic readM;
	logic writeM;
	logic halted;

	logic [`WORD_SIZE-1:0] image [MEM_WORDS];
	logic [`WORD_SIZE-1:0] mem [MEM_WORDS];
	logic [1:0] delay_cnt = '0;
	expect_t expects [$];
	int pass_count = 0;
	int fail_count = 0;

	cpu_core cpu_core_i (
		.ackOutput(ackOutput),
		.reset_n(reset_n),
		.data_in(data_in),
		.inputReady(inputReady),
		.write_ack(write_ack),
		.address(address),
		.data_out(data_out),
		.readM(readM),
		.writeM(writeM),
		.halted(halted)
	);

	initial begin
		ackOutput = 1'b0;
		forever #5 ackOutput = ~ackOutput;
	end

	// Memory model answering each strobe after 0 to 3 idle cycles
	initial begin
		void'($urandom(SEED));
		forever begin
			@(posedge ackOutput);
			inputReady <= 1'b0;
			write_ack <= 1'b0;
			if (!reset_n) begin
				for (int i = 0; i < MEM_WORDS; i++) begin
					mem[i] = image[i];
				end
				delay_cnt <= '0;
			end else if ((readM || writeM) && !inputReady && !write_ack) begin
				if (delay_cnt != 2'd0) begin
					delay_cnt <= delay_cnt - 2'd1;
				end else begin
					if (readM) begin
						data_in <= mem[address[7:0]];
						inputReady <= 1'b1;
					end else begin
						mem[address[7:0]] = data_out;
						write_ack <= 1'b1;
					end
					delay_cnt <= 2'($urandom % 4);
				end
			end
		end
	end

	task automatic load_testdata();
		int fd;
		int n;
		logic [7:0] tag;
		logic [127:0] name;
		logic [8*80-1:0] rest;
		logic [15:0] addr;
		logic [15:0] value;
		expect_t e;
		// Background pattern outside the loaded words
		for (int i = 0; i < MEM_WORDS; i++) begin
			image[i] = 16'hD000 | 16'(i);
		end
		fd = $fopen("tb/cpu_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file tb/cpu_testdata.txt");
			fail_count++;
		end else begin
			while ($fscanf(fd, "%s", tag) == 1) begin
				if (tag == "M") begin
					n = $fscanf(fd, "%h %h", addr, value);
					if (n != 2) begin
						$display("Malformed memory line in the test data file");
						fail_count++;
					end
					image[addr[7:0]] = value;
				end else if (tag == "E") begin
					n = $fscanf(fd, "%s %h %h", name, addr, value);
					if (n != 3) begin
						$display("Malformed expected-result line in the test data file");
						fail_count++;
					end
					e.name = name;
					e.addr = addr[7:0];
					e.value = value;
					expects.push_back(e);
				end else begin
					n = $fgets(rest, fd);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input logic [127:0] name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual === expected) begin
			pass_count++;
			$display("PASS %0s: 0x%04h", name, actual);
		end else begin
			fail_count++;
			$display("Error: %0s expected 0x%04h actual 0x%04h", name, expected, actual);
		end
	endtask

	initial begin
		int cycles;
		load_testdata();
		repeat (8) @(posedge ackOutput);
		reset_n <= 1'b1;
		cycles = 0;
		while (!halted && cycles < MAX_CYCLES) begin
			@(negedge ackOutput);
			cycles++;
		end
		if (!halted) begin
			$display("Timeout: the core never halted within %0d cycles", MAX_CYCLES);
			fail_count++;
		end else begin
			// Idle time to catch stray stores after HLT
			repeat (10) @(negedge ackOutput);
			check_value(128'("halted_held"), 16'd1, 16'(halted));
			if (expects.size() == 0) begin
				$display("No expected results were loaded from the test data file");
				fail_count++;
			end
			foreach (expects[i]) begin
				check_value(expects[i].name, expects[i].value, mem[expects[i].addr]);
			end
		end
		$display("Summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb/cpu_asserts.sv */
`include "cpu_macros.svh"

module cpu_asserts (
	input logic ackOutput,
	input logic reset_n,
	input logic readM,
	input logic writeM,
	input logic halted,
	input logic [`WORD_SIZE-1:0] address
);

	// One strobe at a time
	strobe_exclusive: assert property (
		@(posedge ackOutput) disable iff (!reset_n) !(readM && writeM)
	) else $error("readM and writeM are high in the same cycle");

	// Address held until the memory answers
	address_stable: assert property (
		@(posedge ackOutput) disable iff (!reset_n)
		((readM && $past(readM)) || (writeM && $past(writeM))) |-> (address == $past(address))
	) else $error("address changed while a memory strobe was held");

	halt_quiet: assert property (
		@(posedge ackOutput) disable iff (!reset_n) halted |-> (!readM && !writeM)
	) else $error("memory strobe high after the core halted");

endmodule

bind cpu_core cpu_asserts cpu_asserts_i (
	.ackOutput(ackOutput),
	.reset_n(reset_n),
	.readM(readM),
	.writeM(writeM),
	.halted(halted),
	.address(address)
);

/* src/cpu_core.sv */
`include "cpu_macros.svh"

module cpu_core (
	input  logic ackOutput,
	input  logic reset_n,
	input  logic [`WORD_SIZE-1:0] data_in,
	input  logic inputReady,
	input  logic write_ack,
	output logic [`WORD_SIZE-1:0] address,
	output logic [`WORD_SIZE-1:0] data_out,
	output logic readM,
	output logic writeM,
	output logic halted
);

	cpu_pkg::instr_t instr;
	cpu_pkg::dp_ctrl_t ctrl;
	cpu_pkg::reg_addr_t write_addr;
	logic [`WORD_SIZE-1:0] pc_target;
	logic [`WORD_SIZE-1:0] pc;
	logic [`WORD_SIZE-1:0] pc_plus1;
	logic [`WORD_SIZE-1:0] read_data1;
	logic [`WORD_SIZE-1:0] read_data2;
	logic [`WORD_SIZE-1:0] imm_ext;
	logic [`WORD_SIZE-1:0] alu_a;
	logic [`WORD_SIZE-1:0] alu_b;
	logic [`WORD_SIZE-1:0] alu_result;
	logic [`WORD_SIZE-1:0] wb_data;
	logic zero;
	logic negative;
	logic addr_sel_mem;

	assign imm_ext = cpu_pkg::sext_imm(instr.body.f.low.imm);

	assign alu_a = (ctrl.a_sel == cpu_pkg::A_IMM) ? imm_ext : read_data1;

	always_comb begin
		case (ctrl.b_sel)
			cpu_pkg::B_IMM: alu_b = imm_ext;
			cpu_pkg::B_ONE: alu_b = `WORD_SIZE'd1;
			cpu_pkg::B_EIGHT: alu_b = `WORD_SIZE'd8;
			default: alu_b = read_data2;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			cpu_pkg::WB_LOAD: wb_data = data_in;
			cpu_pkg::WB_PC: wb_data = pc_plus1;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		case (ctrl.dest_sel)
			cpu_pkg::DEST_RT: write_addr = instr.body.f.rt;
			cpu_pkg::DEST_R2: write_addr = cpu_pkg::reg_addr_t'(2);
			default: write_addr = instr.body.f.low.r.rd;
		endcase
	end

	// Effective address during memory states, pc otherwise
	assign address = addr_sel_mem ? alu_result : pc;
	assign data_out = read_data2;

	cpu_fsm u_fsm (
		.ackOutput(ackOutput),
		.reset_n(reset_n),
		.data_in(data_in),
		.inputReady(inputReady),
		.write_ack(write_ack),
		.zero(zero),
		.negative(negative),
		.rs_data(read_data1),
		.pc_plus1(pc_plus1),
		.instr(instr),
		.ctrl(ctrl),
		.pc_target(pc_target),
		.readM(readM),
		.writeM(writeM),
		.addr_sel_mem(addr_sel_mem),
		.halted(halted)
	);

	pc_counter u_pc (
		.ackOutput(ackOutput),
		.reset_n(reset_n),
		.inc(ctrl.pc_inc),
		.load(ctrl.pc_load),
		.target(pc_target),
		.pc(pc),
		.pc_plus1(pc_plus1)
	);

	register_file u_regs (
		.ackOutput(ackOutput),
		.reset_n(reset_n),
		.read_addr1(instr.body.f.rs),
		.read_addr2(instr.body.f.rt),
		.write_addr(write_addr),
		.write_en(ctrl.reg_write),
		.write_data(wb_data),
		.read_data1(read_data1),
		.read_data2(read_data2)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.zero(zero),
		.negative(negative)
	);

endmodule

/* src/cpu_fsm.sv */
`include "cpu_macros.svh"

module cpu_fsm (
	input  logic ackOutput,
	input  logic reset_n,
	input  logic [`WORD_SIZE-1:0] data_in,
	input  logic inputReady,
	input  logic write_ack,
	input  logic zero,
	input  logic negative,
	input  logic [`WORD_SIZE-1:0] rs_data,
	input  logic [`WORD_SIZE-1:0] pc_plus1,
	output cpu_pkg::instr_t instr,
	output cpu_pkg::dp_ctrl_t ctrl,
	output logic [`WORD_SIZE-1:0] pc_target,
	output logic readM,
	output logic writeM,
	output logic addr_sel_mem,
	output logic halted
);

	cpu_pkg::state_e state;
	cpu_pkg::state_e state_next;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::func_e func;
	cpu_pkg::dp_ctrl_t dec;
	logic [7:0] imm;
	logic is_load;
	logic is_store;
	logic is_halt;
	logic is_branch;
	logic is_jump;
	logic writes_reg;
	logic taken;

	assign opcode = instr.opcode;
	assign func = instr.body.f.low.r.func;
	assign imm = instr.body.f.low.imm;

	always_ff @(posedge ackOutput) begin
		if (!reset_n) begin
			instr <= '0;
		end else if (state == cpu_pkg::S_FETCH && inputReady) begin
			instr <= cpu_pkg::instr_t'(data_in);
		end
	end

	// Opcode and function decode
	always_comb begin
		dec = '0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_halt = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		writes_reg = 1'b0;
		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				dec.dest_sel = cpu_pkg::DEST_RD;
				writes_reg = (func <= cpu_pkg::FN_SHR) || (func == cpu_pkg::FN_JRL);
				case (func)
					cpu_pkg::FN_ADD: dec.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUB: dec.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND: dec.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_ORR: dec.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_NOT: dec.alu_op = cpu_pkg::ALU_NOT;
					cpu_pkg::FN_TCP: dec.alu_op = cpu_pkg::ALU_TCP;
					cpu_pkg::FN_SHL: begin
						dec.alu_op = cpu_pkg::ALU_SHL;
						dec.b_sel = cpu_pkg::B_ONE;
					end
					cpu_pkg::FN_SHR: begin
						dec.alu_op = cpu_pkg::ALU_SHR;
						dec.b_sel = cpu_pkg::B_ONE;
					end
					cpu_pkg::FN_JPR: is_jump = 1'b1;
					cpu_pkg::FN_JRL: begin
						is_jump = 1'b1;
						dec.wb_sel = cpu_pkg::WB_PC;
						dec.dest_sel = cpu_pkg::DEST_R2;
					end
					cpu_pkg::FN_HLT: is_halt = 1'b1;
					default: ;
				endcase
			end
			cpu_pkg::OP_ADI, cpu_pkg::OP_ORI, cpu_pkg::OP_LHI, cpu_pkg::OP_LWD: begin
				writes_reg = (opcode != cpu_pkg::OP_LWD);
				is_load = (opcode == cpu_pkg::OP_LWD);
				dec.dest_sel = cpu_pkg::DEST_RT;
				dec.b_sel = cpu_pkg::B_IMM;
				dec.wb_sel = is_load ? cpu_pkg::WB_LOAD : cpu_pkg::WB_ALU;
				if (opcode == cpu_pkg::OP_ORI) begin
					dec.alu_op = cpu_pkg::ALU_OR;
				end else if (opcode == cpu_pkg::OP_LHI) begin
					// imm << 8
					dec.alu_op = cpu_pkg::ALU_SHL;
					dec.a_sel = cpu_pkg::A_IMM;
					dec.b_sel = cpu_pkg::B_EIGHT;
				end
			end
			cpu_pkg::OP_SWD: begin
				is_store = 1'b1;
				dec.b_sel = cpu_pkg::B_IMM;
			end
			cpu_pkg::OP_BNE, cpu_pkg::OP_BEQ: begin
				is_branch = 1'b1;
				dec.alu_op = cpu_pkg::ALU_SUB;
			end
			cpu_pkg::OP_BGZ, cpu_pkg::OP_BLZ: begin
				// rs | 1 carries the exact sign of rs
				is_branch = 1'b1;
				dec.alu_op = cpu_pkg::ALU_OR;
				dec.b_sel = cpu_pkg::B_ONE;
			end
			cpu_pkg::OP_JMP: is_jump = 1'b1;
			cpu_pkg::OP_JAL: begin
				is_jump = 1'b1;
				writes_reg = 1'b1;
				dec.wb_sel = cpu_pkg::WB_PC;
				dec.dest_sel = cpu_pkg::DEST_R2;
			end
			default: ;
		endcase
	end

	always_comb begin
		taken = is_jump;
		if (is_branch) begin
			case (opcode)
				cpu_pkg::OP_BNE: taken = !zero;
				cpu_pkg::OP_BEQ: taken = zero;
				cpu_pkg::OP_BGZ: taken = !negative && (rs_data != '0);
				default: taken = negative;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			cpu_pkg::OP_JMP, cpu_pkg::OP_JAL: begin
				pc_target = {{(`WORD_SIZE-12){1'b0}}, instr.body.target};
			end
			cpu_pkg::OP_RTYPE: pc_target = rs_data;
			default: pc_target = pc_plus1 + cpu_pkg::sext_imm(imm);
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			cpu_pkg::S_FETCH: if (inputReady) state_next = cpu_pkg::S_DECODE;
			cpu_pkg::S_DECODE: state_next = is_halt ? cpu_pkg::S_HALT : cpu_pkg::S_EXECUTE;
			cpu_pkg::S_EXECUTE: begin
				if (is_load) begin
					state_next = cpu_pkg::S_MEM_READ;
				end else if (is_store) begin
					state_next = cpu_pkg::S_MEM_WRITE;
				end else begin
					state_next = cpu_pkg::S_WRITEBACK;
				end
			end
			cpu_pkg::S_MEM_READ: if (inputReady) state_next = cpu_pkg::S_WRITEBACK;
			cpu_pkg::S_MEM_WRITE: if (write_ack) state_next = cpu_pkg::S_FETCH;
			cpu_pkg::S_WRITEBACK: state_next = cpu_pkg::S_FETCH;
			cpu_pkg::S_HALT: state_next = cpu_pkg::S_HALT;
			default: state_next = cpu_pkg::S_FETCH;
		endcase
	end

	// Strobes are registered from the next state
	always_ff @(posedge ackOutput) begin
		if (!reset_n) begin
			state <= cpu_pkg::S_FETCH;
			readM <= 1'b0;
			writeM <= 1'b0;
		end else begin
			state <= state_next;
			readM <= (state_next == cpu_pkg::S_FETCH) || (state_next == cpu_pkg::S_MEM_READ);
			writeM <= (state_next == cpu_pkg::S_MEM_WRITE);
		end
	end

	// Load data is written on the inputReady cycle itself
	always_comb begin
		ctrl = dec;
		ctrl.reg_write = (state == cpu_pkg::S_WRITEBACK && writes_reg)
			|| (state == cpu_pkg::S_MEM_READ && inputReady && is_load);
		ctrl.pc_load = (state == cpu_pkg::S_WRITEBACK) && taken;
		ctrl.pc_inc = (state == cpu_pkg::S_WRITEBACK && !taken)
			|| (state == cpu_pkg::S_MEM_WRITE && write_ack);
	end

	assign addr_sel_mem = (state == cpu_pkg::S_MEM_READ) || (state == cpu_pkg::S_MEM_WRITE);
	assign halted = (state == cpu_pkg::S_HALT);

endmodule

/* src/pc_counter.sv */
`include "cpu_macros.svh"

module pc_counter (
	input  logic ackOutput,
	input  logic reset_n,
	input  logic inc,
	input  logic load,
	input  logic [`WORD_SIZE-1:0] target,
	output logic [`WORD_SIZE-1:0] pc,
	output logic [`WORD_SIZE-1:0] pc_plus1
);

	// Link value and branch base
	assign pc_plus1 = pc + 1'b1;

	always_ff @(posedge ackOutput) begin
		if (!reset_n) begin
			pc <= `RESET_PC;
		end else if (load) begin
			pc <= target;
		end else if (inc) begin
			pc <= pc_plus1;
		end
	end

endmodule

/* src/register_file.sv */
`include "cpu_macros.svh"

module register_file (
	input  logic ackOutput,
	input  logic reset_n,
	input  cpu_pkg::reg_addr_t read_addr1,
	input  cpu_pkg::reg_addr_t read_addr2,
	input  cpu_pkg::reg_addr_t write_addr,
	input  logic write_en,
	input  logic [`WORD_SIZE-1:0] write_data,
	output logic [`WORD_SIZE-1:0] read_data1,
	output logic [`WORD_SIZE-1:0] read_data2
);

	logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

	always_ff @(posedge ackOutput) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// Asynchronous read ports
	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

endmodule

/* src/alu.sv */
`include "cpu_macros.svh"

module alu (
	input  logic [`WORD_SIZE-1:0] a,
	input  logic [`WORD_SIZE-1:0] b,
	input  cpu_pkg::alu_op_e op,
	output logic [`WORD_SIZE-1:0] result,
	output logic zero,
	output logic negative
);

	localparam int SH_W = $clog2(`WORD_SIZE);

	logic [SH_W-1:0] shamt;

	assign shamt = b[SH_W-1:0];

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = a + b;
			cpu_pkg::ALU_SUB: result = a - b;
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR: result = a | b;
			cpu_pkg::ALU_NOT: result = ~a;
			cpu_pkg::ALU_TCP: result = ~a + 1'b1;
			cpu_pkg::ALU_SHL: result = a << shamt;
			// Arithmetic shift keeps the sign bit
			cpu_pkg::ALU_SHR: result = $signed(a) >>> shamt;
			default: result = a;
		endcase
	end

	// Flags for branch decisions
	assign zero = (result == '0);
	assign negative = result[`WORD_SIZE-1];

endmodule

/* src/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		OP_BNE = 4'd0, OP_BEQ = 4'd1, OP_BGZ = 4'd2, OP_BLZ = 4'd3,
		OP_ADI = 4'd4, OP_ORI = 4'd5, OP_LHI = 4'd6, OP_LWD = 4'd7, OP_SWD = 4'd8,
		OP_JMP = 4'd9, OP_JAL = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
		FN_NOT = 6'd4, FN_TCP = 6'd5, FN_SHL = 6'd6, FN_SHR = 6'd7,
		FN_JPR = 6'd25, FN_JRL = 6'd26, FN_HLT = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
	} alu_op_e;

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_EXECUTE, S_MEM_READ, S_MEM_WRITE, S_WRITEBACK, S_HALT
	} state_e;

	// Operand and write-back select codes
	localparam logic A_REG = 1'b0;
	localparam logic A_IMM = 1'b1;
	localparam logic [1:0] B_REG = 2'd0;
	localparam logic [1:0] B_IMM = 2'd1;
	localparam logic [1:0] B_ONE = 2'd2;
	localparam logic [1:0] B_EIGHT = 2'd3;
	localparam logic [1:0] WB_ALU = 2'd0;
	localparam logic [1:0] WB_LOAD = 2'd1;
	localparam logic [1:0] WB_PC = 2'd2;
	localparam logic [1:0] DEST_RD = 2'd0;
	localparam logic [1:0] DEST_RT = 2'd1;
	localparam logic [1:0] DEST_R2 = 2'd2;

	// Low byte is either rd/func or the 8-bit immediate
	typedef struct packed {
		reg_addr_t rd;
		func_e func;
	} rfield_t;

	typedef union packed {
		rfield_t r;
		logic [7:0] imm;
	} low_t;

	typedef struct packed {
		reg_addr_t rs;
		reg_addr_t rt;
		low_t low;
	} fields_t;

	typedef union packed {
		fields_t f;
		logic [11:0] target;
	} body_t;

	typedef struct packed {
		opcode_e opcode;
		body_t body;
	} instr_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic a_sel;
		logic [1:0] b_sel;
		logic [1:0] wb_sel;
		logic [1:0] dest_sel;
		logic reg_write;
		logic pc_load;
		logic pc_inc;
	} dp_ctrl_t;

	function automatic logic [`WORD_SIZE-1:0] sext_imm(input logic [7:0] imm);
		return {{(`WORD_SIZE-8){imm[7]}}, imm};
	endfunction

endpackage

/* src/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and address width
`define WORD_SIZE 16

`define NUM_REGS 4

// First fetch address after reset
`define RESET_PC 16'h0000

`endif
